// File: Bender.yml
package:
  name: rename_front

sources:
  - logic/rename_pkg.sv
  - logic/instr_decoder.sv
  - logic/decode_stage.sv
  - logic/free_list.sv
  - logic/rename_map.sv
  - logic/rename_stage.sv
  - logic/rename_front_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/rename_checker.sv
      - verification/rename_front_tb.sv

// File: logic/decode_stage.sv
module decode_stage (
   input  logic                      clk,
   input  logic                      arst_n,
   input  rename_pkg::fetch_bundle_t fetch_in,
   input  logic                      pipe_stall,
   input  logic                      flush_valid,
   output logic                      fetch_ready,
   output rename_pkg::dec_bundle_t   dec_bundle
);

   rename_pkg::fetch_bundle_t fetch_q;                 // Fetch register payload
   logic [1:0]                fetch_vld_q;
   rename_pkg::fetch_bundle_t fetch_cur;               // Payload with live valids
   rename_pkg::dec_bundle_t   dec_d;                   // Decoder outputs
   rename_pkg::dec_bundle_t   dec_q;                   // Decode-to-rename payload
   logic [1:0]                dec_vld_q;

   assign fetch_ready = !pipe_stall;                   // Accept only when moving

   //////////////////////////////
   // Fetch register
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fetch_vld_q <= '0;
      end else if (flush_valid) begin                  // Flush beats stall
         fetch_vld_q <= '0;
      end else if (!pipe_stall) begin
         fetch_vld_q <= {fetch_in.slot[1].valid, fetch_in.slot[0].valid};
      end
   end

   always_ff @(posedge clk) begin
      if (!pipe_stall) begin
         fetch_q <= fetch_in;
      end
   end

   always_comb begin
      fetch_cur = fetch_q;
      fetch_cur.slot[0].valid = fetch_vld_q[0];
      fetch_cur.slot[1].valid = fetch_vld_q[1];
   end

   // One decoder per slot
   for (genvar i = 0; i < 2; i++) begin : g_dec
      instr_decoder inst_decoder (
         .instr_in (fetch_cur.slot[i]),
         .dec_out  (dec_d.slot[i])
      );
   end

   //////////////////////////////
   // Decode-to-rename register
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec_vld_q <= '0;
      end else if (flush_valid) begin
         dec_vld_q <= '0;
      end else if (!pipe_stall) begin
         dec_vld_q <= {dec_d.slot[1].valid, dec_d.slot[0].valid};
      end
   end

   always_ff @(posedge clk) begin
      if (!pipe_stall) begin
         dec_q <= dec_d;
      end
   end

   always_comb begin
      dec_bundle = dec_q;
      dec_bundle.slot[0].valid = dec_vld_q[0];
      dec_bundle.slot[1].valid = dec_vld_q[1];
   end

endmodule

// File: logic/free_list.sv
module free_list (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [1:0]                     alloc,
   output logic [rename_pkg::PRD_W-1:0]   free_prd0,
   output logic [rename_pkg::PRD_W-1:0]   free_prd1,
   output logic                           can_alloc,
   input  rename_pkg::retire_bundle_t     release_in
);

   localparam int PW       = rename_pkg::PRD_W;
   localparam int DEPTH    = rename_pkg::PHYS_REGS;
   localparam int INIT_CNT = rename_pkg::PHYS_REGS - rename_pkg::ARCH_REGS;  // Not in identity map

   localparam logic [PW:0] MIN_CNT = (PW+1)'(2);      // Room for a full bundle

   logic [PW-1:0] fl_mem [DEPTH];                      // Queue storage
   logic [PW-1:0] head_q;                              // Next entry to pop
   logic [PW-1:0] tail_q;                              // Next slot to push
   logic [PW:0]   count_q;                             // 0 to 64 entries
   logic [PW-1:0] head_nxt;
   logic [PW-1:0] push_ptr1;                           // Slot for release 1
   logic [1:0]    pop_cnt;
   logic [1:0]    push_cnt;

   assign pop_cnt   = 2'(alloc[0]) + 2'(alloc[1]);
   assign push_cnt  = 2'(release_in.slot[0].valid) + 2'(release_in.slot[1].valid);
   assign head_nxt  = head_q + 1'b1;                   // Wraps at 64
   assign push_ptr1 = release_in.slot[0].valid ? tail_q + 1'b1 : tail_q;  // Packs behind slot 0

   assign free_prd0 = fl_mem[head_q];
   assign free_prd1 = fl_mem[head_nxt];
   assign can_alloc = count_q >= MIN_CNT;

   //////////////////////////////
   // Storage
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            fl_mem[i] <= (i < INIT_CNT) ? PW'(i + rename_pkg::ARCH_REGS) : '0;  // p32 up
         end
      end else begin
         if (release_in.slot[0].valid) begin
            fl_mem[tail_q] <= release_in.slot[0].prd_old;
         end
         if (release_in.slot[1].valid) begin
            fl_mem[push_ptr1] <= release_in.slot[1].prd_old;
         end
      end
   end

   //////////////////////////////
   // Pointers and count
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         head_q  <= '0;
         tail_q  <= PW'(INIT_CNT);
         count_q <= (PW+1)'(INIT_CNT);
      end else begin
         head_q  <= head_q + PW'(pop_cnt);
         tail_q  <= tail_q + PW'(push_cnt);
         count_q <= count_q + (PW+1)'(push_cnt) - (PW+1)'(pop_cnt);  // Push visible next edge
      end
   end

endmodule

// File: logic/instr_decoder.sv
module instr_decoder (
   input  rename_pkg::fetch_slot_t instr_in,
   output rename_pkg::dec_slot_t   dec_out
);

   // RV32I major opcodes, bits 6:0
   typedef enum logic [6:0] {
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_lui    = 7'b0110111,
      opc_auipc  = 7'b0010111,
      opc_jal    = 7'b1101111,
      opc_jalr   = 7'b1100111
   } major_opcode_e;

   logic [rename_pkg::XLEN-1:0] word;                  // Instr actually decoded
   rename_pkg::op_class_e       op;
   logic                        writes_class;          // Class has a destination

   assign word = instr_in.valid ? instr_in.instr : rename_pkg::NOP_INSTR;  // Bubble decodes as NOP

   always_comb begin
      case (major_opcode_e'(word[6:0]))
         opc_op:              op = rename_pkg::op_alu_reg;
         opc_op_imm:          op = rename_pkg::op_alu_imm;
         opc_load:            op = rename_pkg::op_load;
         opc_store:           op = rename_pkg::op_store;
         opc_branch:          op = rename_pkg::op_branch;
         opc_lui, opc_auipc:  op = rename_pkg::op_lui;    // Both upper immediate
         opc_jal, opc_jalr:   op = rename_pkg::op_jump;   // Link reg in rd
         default:             op = rename_pkg::op_other;
      endcase
   end

   assign writes_class = op inside {rename_pkg::op_alu_reg, rename_pkg::op_alu_imm,
                                    rename_pkg::op_load, rename_pkg::op_lui,
                                    rename_pkg::op_jump};

   always_comb begin
      dec_out.valid     = instr_in.valid;
      dec_out.pc        = instr_in.valid ? instr_in.pc : '0;
      dec_out.op        = op;
      dec_out.rd        = word[11:7];
      dec_out.rs1       = word[19:15];                 // Raw field, renamed regardless
      dec_out.rs2       = word[24:20];
      dec_out.writes_rd = writes_class && (word[11:7] != '0);  // x0 never renamed
   end

endmodule

// File: logic/rename_front_top.sv
module rename_front_top (
   input  logic                       clk,
   input  logic                       arst_n,
   input  rename_pkg::fetch_bundle_t  fetch_in,
   output logic                       fetch_ready,
   input  logic                       dispatch_ready,
   input  logic                       flush_valid,
   input  rename_pkg::retire_bundle_t retire_in,
   output rename_pkg::ren_bundle_t    ren_out
);

   //////////////////////////////
   // Stage wiring
   //////////////////////////////

   rename_pkg::dec_bundle_t dec_bundle;                // Decode-to-rename register
   logic                    pipe_stall;                // From rename stage only

   decode_stage inst_decode_stage (
      .clk         (clk),
      .arst_n      (arst_n),
      .fetch_in    (fetch_in),
      .pipe_stall  (pipe_stall),
      .flush_valid (flush_valid),
      .fetch_ready (fetch_ready),
      .dec_bundle  (dec_bundle)
   );

   rename_stage inst_rename_stage (
      .clk            (clk),
      .arst_n         (arst_n),
      .dec_bundle     (dec_bundle),
      .retire_in      (retire_in),
      .dispatch_ready (dispatch_ready),
      .flush_valid    (flush_valid),
      .pipe_stall     (pipe_stall),
      .ren_out        (ren_out)
   );

endmodule

// File: logic/rename_map.sv
module rename_map (
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic [5:0][rename_pkg::ARD_W-1:0]    rd_arch,
   output logic [5:0][rename_pkg::PRD_W-1:0]    rd_phys,
   input  logic [1:0]                           wr_en,
   input  logic [rename_pkg::ARD_W-1:0]         wr_arch0,
   input  logic [rename_pkg::ARD_W-1:0]         wr_arch1,
   input  logic [rename_pkg::PRD_W-1:0]         wr_phys0,
   input  logic [rename_pkg::PRD_W-1:0]         wr_phys1
);

   localparam int PW       = rename_pkg::PRD_W;
   localparam int RD_PORTS = 6;                        // 4 sources plus 2 old dests

   logic [PW-1:0] map_q [rename_pkg::ARCH_REGS];       // Arch to phys table

   //////////////////////////////
   // Read ports
   //////////////////////////////

   always_comb begin
      for (int i = 0; i < RD_PORTS; i++) begin
         rd_phys[i] = map_q[rd_arch[i]];               // Old value within the cycle
      end
   end

   //////////////////////////////
   // Write ports
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            map_q[i] <= PW'(i);                        // Identity at reset
         end
      end else begin
         if (wr_en[0]) begin
            map_q[wr_arch0] <= wr_phys0;
         end
         if (wr_en[1]) begin                           // Written last so slot 1 wins
            map_q[wr_arch1] <= wr_phys1;
         end
      end
   end

endmodule

// File: logic/rename_pkg.sv
package rename_pkg;

   //////////////////////////////
   // Register file sizes
   //////////////////////////////

   localparam int ARCH_REGS = 32;                      // x0 to x31
   localparam int ARD_W     = $clog2(ARCH_REGS);       // Arch index width
   localparam int PHYS_REGS = 64;                      // Physical register file depth
   localparam int PRD_W     = $clog2(PHYS_REGS);       // Phys index width
   localparam int XLEN      = 32;                      // Instr and PC width

   localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

   //////////////////////////////
   // Operation classes
   //////////////////////////////

   typedef enum logic [2:0] {
      op_alu_reg,                                      // R-type ALU
      op_alu_imm,                                      // I-type ALU
      op_load,
      op_store,
      op_branch,
      op_lui,                                          // Upper immediate
      op_jump,                                         // JAL and JALR
      op_other                                         // Fence, system, unknown
   } op_class_e;

   //////////////////////////////
   // Pipeline payloads
   //////////////////////////////

   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] instr;
   } fetch_slot_t;

   typedef struct packed {
      fetch_slot_t [1:0] slot;                         // Slot 0 is the older one
   } fetch_bundle_t;

   typedef struct packed {
      logic             valid;
      logic [XLEN-1:0]  pc;
      op_class_e        op;
      logic [ARD_W-1:0] rd;
      logic [ARD_W-1:0] rs1;
      logic [ARD_W-1:0] rs2;
      logic             writes_rd;                     // Writing class and rd != x0
   } dec_slot_t;

   typedef struct packed {
      dec_slot_t [1:0] slot;
   } dec_bundle_t;

   typedef struct packed {
      logic             valid;
      logic [XLEN-1:0]  pc;
      op_class_e        op;
      logic [ARD_W-1:0] rd;
      logic [PRD_W-1:0] prd;                           // New mapping of rd
      logic [PRD_W-1:0] prd_old;                       // Mapping freed at retire
      logic [PRD_W-1:0] prs1;
      logic [PRD_W-1:0] prs2;
      logic             writes_rd;
   } ren_slot_t;

   typedef struct packed {
      ren_slot_t [1:0] slot;
   } ren_bundle_t;

   typedef struct packed {
      logic             valid;
      logic [PRD_W-1:0] prd_old;                       // Register back to free list
   } retire_slot_t;

   typedef struct packed {
      retire_slot_t [1:0] slot;
   } retire_bundle_t;

endpackage

// File: logic/rename_stage.sv
module rename_stage (
   input  logic                       clk,
   input  logic                       arst_n,
   input  rename_pkg::dec_bundle_t    dec_bundle,
   input  rename_pkg::retire_bundle_t retire_in,
   input  logic                       dispatch_ready,
   input  logic                       flush_valid,
   output logic                       pipe_stall,
   output rename_pkg::ren_bundle_t    ren_out
);

   localparam int PW = rename_pkg::PRD_W;

   logic                               can_alloc;      // At least two free regs
   logic                               advance;        // Rename commits this edge
   logic [1:0]                         wr_slot;        // Slot needs a new prd
   logic [1:0]                         alloc;
   logic [PW-1:0]                      free_prd0;
   logic [PW-1:0]                      free_prd1;
   logic [1:0][PW-1:0]                 new_prd;
   logic [5:0][rename_pkg::ARD_W-1:0]  rd_arch;
   logic [5:0][PW-1:0]                 rd_phys;
   rename_pkg::ren_bundle_t            ren_d;
   rename_pkg::ren_bundle_t            ren_q;          // Output payload
   logic [1:0]                         ren_vld_q;

   //////////////////////////////
   // Stall and allocation
   //////////////////////////////

   assign pipe_stall = !dispatch_ready || !can_alloc;  // Single global stall
   assign advance    = !pipe_stall && !flush_valid;    // Flushed bundle takes no regs

   assign wr_slot[0] = dec_bundle.slot[0].valid && dec_bundle.slot[0].writes_rd;
   assign wr_slot[1] = dec_bundle.slot[1].valid && dec_bundle.slot[1].writes_rd;
   assign alloc      = advance ? wr_slot : 2'b00;

   assign new_prd[0] = free_prd0;
   assign new_prd[1] = wr_slot[0] ? free_prd1 : free_prd0;  // Head goes to oldest writer

   // Lanes 0 to 3 are sources, 4 and 5 the old dest mappings
   assign rd_arch[0] = dec_bundle.slot[0].rs1;
   assign rd_arch[1] = dec_bundle.slot[0].rs2;
   assign rd_arch[2] = dec_bundle.slot[1].rs1;
   assign rd_arch[3] = dec_bundle.slot[1].rs2;
   assign rd_arch[4] = dec_bundle.slot[0].rd;
   assign rd_arch[5] = dec_bundle.slot[1].rd;

   free_list inst_free_list (
      .clk        (clk),
      .arst_n     (arst_n),
      .alloc      (alloc),
      .free_prd0  (free_prd0),
      .free_prd1  (free_prd1),
      .can_alloc  (can_alloc),
      .release_in (retire_in)                          // Sampled even when stalled
   );

   rename_map inst_rename_map (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd_arch  (rd_arch),
      .rd_phys  (rd_phys),
      .wr_en    (alloc),
      .wr_arch0 (dec_bundle.slot[0].rd),
      .wr_arch1 (dec_bundle.slot[1].rd),
      .wr_phys0 (new_prd[0]),
      .wr_phys1 (new_prd[1])
   );

   //////////////////////////////
   // Rename and bypass
   //////////////////////////////

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         ren_d.slot[i].valid     = dec_bundle.slot[i].valid;
         ren_d.slot[i].pc        = dec_bundle.slot[i].pc;
         ren_d.slot[i].op        = dec_bundle.slot[i].op;
         ren_d.slot[i].rd        = dec_bundle.slot[i].rd;
         ren_d.slot[i].writes_rd = dec_bundle.slot[i].writes_rd;
         ren_d.slot[i].prs1      = rd_phys[2*i];
         ren_d.slot[i].prs2      = rd_phys[2*i+1];
         ren_d.slot[i].prd       = wr_slot[i] ? new_prd[i] : '0;
         ren_d.slot[i].prd_old   = wr_slot[i] ? rd_phys[4+i] : '0;
      end
      if (wr_slot[0]) begin                            // Slot 1 sees slot 0's new prd
         if (dec_bundle.slot[1].rs1 == dec_bundle.slot[0].rd) begin
            ren_d.slot[1].prs1 = new_prd[0];
         end
         if (dec_bundle.slot[1].rs2 == dec_bundle.slot[0].rd) begin
            ren_d.slot[1].prs2 = new_prd[0];
         end
         if (wr_slot[1] && (dec_bundle.slot[1].rd == dec_bundle.slot[0].rd)) begin
            ren_d.slot[1].prd_old = new_prd[0];        // WAW inside bundle
         end
      end
   end

   //////////////////////////////
   // Output register
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ren_vld_q <= '0;
      end else if (flush_valid) begin
         ren_vld_q <= '0;
      end else if (!pipe_stall) begin
         ren_vld_q <= {ren_d.slot[1].valid, ren_d.slot[0].valid};
      end
   end

   always_ff @(posedge clk) begin
      if (!pipe_stall) begin
         ren_q <= ren_d;                               // Held during back-pressure
      end
   end

   always_comb begin
      ren_out = ren_q;
      ren_out.slot[0].valid = ren_vld_q[0];
      ren_out.slot[1].valid = ren_vld_q[1];
   end

endmodule

// File: src.f
logic/rename_pkg.sv
logic/instr_decoder.sv
logic/decode_stage.sv
logic/free_list.sv
logic/rename_map.sv
logic/rename_stage.sv
logic/rename_front_top.sv
verification/tb_clock_gen.sv
verification/rename_checker.sv
verification/rename_front_tb.sv

// File: verification/rename_checker.sv
module rename_checker (
   input  logic                    clk,
   input  logic                    check_en,           // Pattern line active
   input  rename_pkg::ren_bundle_t ren_out,
   input  rename_pkg::ren_bundle_t exp_ren,
   input  logic                    fetch_ready,
   input  logic                    exp_ready,
   output int                      mismatches,
   output int                      checked
);

   timeunit 1ns;
   timeprecision 1ps;

   int err_cnt = 0;
   int cyc_cnt = 0;

   assign mismatches = err_cnt;
   assign checked    = cyc_cnt;

   //////////////////////////////
   // Compare on the falling edge
   //////////////////////////////

   always @(negedge clk) begin
      if (check_en) begin
         cyc_cnt++;
         if (fetch_ready !== exp_ready) begin          // Stall level seen by fetch
            $display("mismatch fetch_ready at %0t: got %h expected %h",
                     $time, fetch_ready, exp_ready);
            err_cnt++;
         end
         for (int i = 0; i < 2; i++) begin
            if (ren_out.slot[i].valid !== exp_ren.slot[i].valid) begin
               $display("mismatch ren_out.slot[%0d].valid at %0t: got %h expected %h",
                        i, $time, ren_out.slot[i].valid, exp_ren.slot[i].valid);
               err_cnt++;
            end else if (exp_ren.slot[i].valid &&
                         (ren_out.slot[i] !== exp_ren.slot[i])) begin  // Payload only if valid
               $display("mismatch ren_out.slot[%0d] at %0t: got %h expected %h",
                        i, $time, ren_out.slot[i], exp_ren.slot[i]);
               err_cnt++;
            end
         end
      end
   end

endmodule

// File: verification/rename_front_tb.sv
module rename_front_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam string PATTERN_FILE = "verification/rename_patterns.txt";
   localparam int    NCOL         = 31;                // Columns per pattern line
   localparam int    CLK_NS       = 40;

   typedef struct packed {
      rename_pkg::fetch_bundle_t  fetch;
      logic                       dispatch_ready;
      logic                       flush_valid;
      rename_pkg::retire_bundle_t retire;
      logic                       exp_ready;
      rename_pkg::ren_bundle_t    exp_ren;
   } pattern_t;

   logic                       clk;
   logic                       arst_n;
   rename_pkg::fetch_bundle_t  fetch_in;
   logic                       fetch_ready;
   logic                       dispatch_ready;
   logic                       flush_valid;
   rename_pkg::retire_bundle_t retire_in;
   rename_pkg::ren_bundle_t    ren_out;
   rename_pkg::ren_bundle_t    exp_ren;            // To checker
   logic                       exp_ready;
   logic                       check_en;
   int                         mismatches;
   int                         checked;
   int                         file_errors = 0;
   int                         n_lines     = 0;
   logic [31:0]                cols [NCOL];        // Tokens of one line
   pattern_t                   pats [$];

   tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(4)) clk_gen0 (.clk(clk), .arst_n(arst_n));

   rename_front_top dut0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .fetch_in       (fetch_in),
      .fetch_ready    (fetch_ready),
      .dispatch_ready (dispatch_ready),
      .flush_valid    (flush_valid),
      .retire_in      (retire_in),
      .ren_out        (ren_out)
   );

   rename_checker check0 (
      .clk         (clk),
      .check_en    (check_en),
      .ren_out     (ren_out),
      .exp_ren     (exp_ren),
      .fetch_ready (fetch_ready),
      .exp_ready   (exp_ready),
      .mismatches  (mismatches),
      .checked     (checked)
   );

   //////////////////////////////
   // Pattern file parsing
   //////////////////////////////

   function automatic int hex_digit(input byte ch);
      if (ch >= "0" && ch <= "9") return ch - "0";
      if (ch >= "a" && ch <= "f") return ch - "a" + 10;
      if (ch >= "A" && ch <= "F") return ch - "A" + 10;
      return -1;                                       // Separator
   endfunction

   task automatic split_hex(input string line, output int n);
      logic [31:0] acc;
      bit          in_tok;
      byte         ch;
      int          digit;
      n      = 0;
      acc    = '0;
      in_tok = 1'b0;
      for (int i = 0; i <= line.len(); i++) begin
         ch    = (i < line.len()) ? line[i] : " ";
         digit = hex_digit(ch);
         if (digit >= 0) begin
            acc    = {acc[27:0], 4'(digit)};
            in_tok = 1'b1;
         end else if (in_tok) begin                    // End of a token
            if (n < NCOL) cols[n] = acc;
            n++;
            acc    = '0;
            in_tok = 1'b0;
         end
      end
   endtask

   function automatic pattern_t cols_to_pattern();
      pattern_t p;
      int       b;
      p = '0;
      for (int s = 0; s < 2; s++) begin
         p.fetch.slot[s].valid = cols[3*s][0];
         p.fetch.slot[s].pc    = cols[3*s+1];
         p.fetch.slot[s].instr = cols[3*s+2];
         p.retire.slot[s].valid   = cols[8+2*s][0];
         p.retire.slot[s].prd_old = cols[9+2*s][5:0];
         b = 13 + 9*s;                                 // Expected slot columns
         p.exp_ren.slot[s].valid     = cols[b][0];
         p.exp_ren.slot[s].pc        = cols[b+1];
         p.exp_ren.slot[s].op        = rename_pkg::op_class_e'(cols[b+2][2:0]);
         p.exp_ren.slot[s].rd        = cols[b+3][4:0];
         p.exp_ren.slot[s].prd       = cols[b+4][5:0];
         p.exp_ren.slot[s].prd_old   = cols[b+5][5:0];
         p.exp_ren.slot[s].prs1      = cols[b+6][5:0];
         p.exp_ren.slot[s].prs2      = cols[b+7][5:0];
         p.exp_ren.slot[s].writes_rd = cols[b+8][0];
      end
      p.dispatch_ready = cols[6][0];
      p.flush_valid    = cols[7][0];
      p.exp_ready      = cols[12][0];
      return p;
   endfunction

   task automatic load_patterns();
      int    fd;
      int    n;
      string line;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         $display("ERROR: the pattern file %s could not be opened", PATTERN_FILE);
         file_errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line.substr(0, 0) == "#") continue;  // Column notes
         split_hex(line, n);
         if (n == 0) continue;
         if (n != NCOL) begin
            $display("ERROR: a pattern line has %0d columns instead of %0d", n, NCOL);
            file_errors++;
         end else begin
            pats.push_back(cols_to_pattern());
         end
      end
      $fclose(fd);
      if (pats.size() == 0) begin
         $display("ERROR: the pattern file holds no pattern lines");
         file_errors++;
      end
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial begin
      fetch_in       <= '0;
      dispatch_ready <= 1'b1;
      flush_valid    <= 1'b0;
      retire_in      <= '0;
      exp_ren        <= '0;
      exp_ready      <= 1'b1;
      check_en       <= 1'b0;
      load_patterns();
      n_lines = pats.size();
      @(posedge arst_n);
      foreach (pats[i]) begin
         @(posedge clk);
         fetch_in       <= pats[i].fetch;
         dispatch_ready <= pats[i].dispatch_ready;
         flush_valid    <= pats[i].flush_valid;        // One line per pulse
         retire_in      <= pats[i].retire;
         exp_ren        <= pats[i].exp_ren;
         exp_ready      <= pats[i].exp_ready;
         check_en       <= 1'b1;
      end
      @(posedge clk);
      check_en <= 1'b0;
      @(posedge clk);
      $display("Checked %0d cycles: %0d mismatches, %0d pattern file errors",
               checked, mismatches, file_errors);
      if (file_errors == 0 && mismatches == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog sized from the pattern count
   initial begin
      #1;
      #((n_lines + 20) * CLK_NS);
      $display("ERROR: the run did not finish in time");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: verification/rename_patterns.txt
# in: f0v f0pc f0instr f1v f1pc f1instr dispatch_ready flush r0v r0prd r1v r1prd | exp fetch_ready
# exp ren_out per slot: valid pc op rd prd prd_old prs1 prs2 writes_rd (slot 0 then slot 1), hex
1 100 3100b3 1 104 628233 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 108 40393 1 10c 4b7 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 110 308023 1 114 720063 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 118 48003 1 11c ef 1 0 0 0 0 0 1 1 100 0 01 20 01 02 03 1 1 104 0 04 21 04 05 06 1
1 120 73 0 0 0 1 0 0 0 0 0 1 1 108 1 07 22 07 08 00 1 1 10c 5 09 23 09 00 00 1
1 124 208533 1 128 a50533 1 0 0 0 0 0 1 1 110 3 00 00 00 20 03 0 1 114 4 00 00 00 21 22 0
1 12c 505b3 0 0 0 1 0 0 0 0 0 1 1 118 2 00 00 00 23 00 0 1 11c 6 01 24 20 00 00 1
1 130 613 1 134 693 1 0 0 0 0 0 1 1 120 7 00 00 00 00 00 0 0 0 0 0 0 0 0 0 0
1 138 713 1 13c 793 1 0 0 0 0 0 1 1 124 0 0a 25 0a 24 02 1 1 128 0 0a 26 25 25 25 1
1 140 813 0 0 0 1 0 0 0 0 0 1 1 12c 0 0b 27 0b 26 00 1 0 0 0 0 0 0 0 0 0
1 144 893 0 0 0 0 0 0 0 0 0 0 1 130 1 0c 28 0c 00 00 1 1 134 1 0d 29 0d 00 00 1
1 144 893 0 0 0 0 0 0 0 0 0 0 1 130 1 0c 28 0c 00 00 1 1 134 1 0d 29 0d 00 00 1
1 144 893 0 0 0 1 0 0 0 0 0 1 1 130 1 0c 28 0c 00 00 1 1 134 1 0d 29 0d 00 00 1
1 148 913 1 14c 993 1 0 0 0 0 0 1 1 138 1 0e 2a 0e 00 00 1 1 13c 1 0f 2b 0f 00 00 1
1 150 a13 1 154 a93 1 0 0 0 0 0 1 1 140 1 10 2c 10 00 00 1 0 0 0 0 0 0 0 0 0
1 158 b13 1 15c b93 1 0 0 0 0 0 1 1 144 1 11 2d 11 00 00 1 0 0 0 0 0 0 0 0 0
1 160 c13 1 164 c93 1 0 0 0 0 0 1 1 148 1 12 2e 12 00 00 1 1 14c 1 13 2f 13 00 00 1
1 168 d13 1 16c d93 1 0 0 0 0 0 1 1 150 1 14 30 14 00 00 1 1 154 1 15 31 15 00 00 1
1 170 e13 1 174 e93 1 0 0 0 0 0 1 1 158 1 16 32 16 00 00 1 1 15c 1 17 33 17 00 00 1
1 178 f13 1 17c f93 1 0 0 0 0 0 1 1 160 1 18 34 18 00 00 1 1 164 1 19 35 19 00 00 1
1 180 113 1 184 193 1 0 0 0 0 0 1 1 168 1 1a 36 1a 00 00 1 1 16c 1 1b 37 1b 00 00 1
1 188 293 0 0 0 1 0 0 0 0 0 1 1 170 1 1c 38 1c 00 00 1 1 174 1 1d 39 1d 00 00 1
1 18c 313 1 190 413 1 0 0 0 0 0 1 1 178 1 1e 3a 1e 00 00 1 1 17c 1 1f 3b 1f 00 00 1
0 0 0 0 0 0 1 0 0 0 0 0 1 1 180 1 02 3c 02 00 00 1 1 184 1 03 3d 03 00 00 1
0 0 0 0 0 0 1 0 0 0 0 0 0 1 188 1 05 3e 05 00 00 1 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 1 0 1 01 1 04 0 1 188 1 05 3e 05 00 00 1 0 0 0 0 0 0 0 0 0
1 194 913 0 0 0 1 0 0 0 0 0 1 1 188 1 05 3e 05 00 00 1 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 1 0 1 07 0 0 0 1 18c 1 06 3f 06 00 00 1 1 190 1 08 01 08 00 00 1
0 0 0 0 0 0 1 0 0 0 0 0 1 1 18c 1 06 3f 06 00 00 1 1 190 1 08 01 08 00 00 1
0 0 0 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 1 0 1 09 1 0a 0 1 194 1 12 04 2e 00 00 1 0 0 0 0 0 0 0 0 0
1 198 993 0 0 0 1 0 0 0 0 0 1 1 194 1 12 04 2e 00 00 1 0 0 0 0 0 0 0 0 0
1 19c b13 1 1a0 b93 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1a4 c13 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 1 1 0 0 0 0 1 1 198 1 13 07 2f 00 00 1 0 0 0 0 0 0 0 0 0
1 1a8 98ab3 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 1 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 1 0 0 0 0 0 0 1 1a8 0 15 09 31 07 00 1 0 0 0 0 0 0 0 0 0

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic arst_n
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;             // Free running
   end

   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;                                  // Release on an edge
   end

endmodule
